// File: include/ahb_settings.svh
`ifndef AHB_SETTINGS_SVH
`define AHB_SETTINGS_SVH

// ################################################
// Bus widths
// ################################################

`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// ################################################
// Memory organisation
// ################################################

// Banks are word interleaved, so a WRAP4 burst visits each bank once.
`define MEM_NUM_BANKS 4
`define MEM_BANK_DEPTH 64

// Clears the low four byte-address bits to find the 16-byte wrap boundary.
`define AHB_WRAP4_MASK 32'hFFFF_FFF0

`endif

// File: hw/ahb_pkg.sv
`include "ahb_settings.svh"

package ahb_pkg;

    // ################################################
    // AHB-Lite bus encodings
    // ################################################

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } hburst_e;

    // One address phase as seen on the bus, 38 bits.
    typedef struct packed {
        logic [`AHB_ADDR_W-1:0] addr;
        logic                   write;
        htrans_e                trans;
        hburst_e                burst;
    } ahb_addr_phase_t;

    // Kind of transfer the address generator is currently serving.
    typedef enum logic [1:0] {
        IDLE_ST   = 2'b00,
        SINGLE_ST = 2'b01,
        WRAP_ST   = 2'b10
    } gen_state_e;

endpackage

// File: hw/mem_pkg.sv
`include "ahb_settings.svh"

package mem_pkg;

    // Derived widths of the banked memory.
    localparam int unsigned WORD_ADDR_W = `AHB_ADDR_W - 2;
    localparam int unsigned BANK_W = $clog2(`MEM_NUM_BANKS);
    localparam int unsigned ROW_W = $clog2(`MEM_BANK_DEPTH);

    // One registered beat for the data phase, 32 bits.
    // The word address is the byte address without its two low bits.
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [WORD_ADDR_W-1:0] word_addr;
    } mem_beat_t;

    // Request to a single bank, 8 bits.
    typedef struct packed {
        logic             en;
        logic             write;
        logic [ROW_W-1:0] row;
    } bank_req_t;

endpackage

// File: hw/burst_addr_gen.sv
`timescale 1ns/1ps
`include "ahb_settings.svh"

module burst_addr_gen
    import ahb_pkg::*;
    import mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`AHB_ADDR_W-1:0] haddr,
    input  logic                   hwrite,
    input  htrans_e                htrans,
    input  hburst_e                hburst,
    input  logic                   hready,
    output mem_beat_t              beat
);

    ahb_addr_phase_t ap;

    gen_state_e state_q;
    gen_state_e state_d;

    logic [`AHB_ADDR_W-1:0] base_q;
    logic [`AHB_ADDR_W-1:0] base_d;
    logic [3:0] offset_q;
    logic [3:0] offset_d;
    logic [1:0] count_q;
    logic [1:0] count_d;

    mem_beat_t beat_d;

    logic [3:0] offset_inc;
    logic [`AHB_ADDR_W-1:0] wrap_addr;

    assign ap = '{addr: haddr, write: hwrite, trans: htrans, burst: hburst};

    // The byte offset is four bits wide, so adding 4 wraps modulo 16 by itself.
    assign offset_inc = offset_q + 4'd4;
    assign wrap_addr = base_q | {{(`AHB_ADDR_W-4){1'b0}}, offset_inc};

    // ################################################
    // Next beat and burst tracking
    // ################################################

    always_comb begin
        state_d = state_q;
        base_d = base_q;
        offset_d = offset_q;
        count_d = count_q;
        beat_d = beat;

        // Everything holds while the current data phase is stretched.
        if (hready) begin
            beat_d = '0;
            case (ap.trans)
                NONSEQ: begin
                    beat_d.valid = 1'b1;
                    beat_d.write = ap.write;
                    beat_d.word_addr = ap.addr[`AHB_ADDR_W-1:2];
                    count_d = 2'd0;
                    if (ap.burst == WRAP4) begin
                        state_d = WRAP_ST;
                        base_d = ap.addr & `AHB_WRAP4_MASK;
                        offset_d = {ap.addr[3:2], 2'b00};
                    end else begin
                        state_d = SINGLE_ST;
                    end
                end
                SEQ: begin
                    if (state_q == WRAP_ST) begin
                        // haddr is ignored here, the wrapped address is generated locally.
                        // SEQs after the fourth beat belong to no WRAP4 burst and get no beat.
                        if (count_q != 2'd3) begin
                            beat_d.valid = 1'b1;
                            beat_d.write = ap.write;
                            beat_d.word_addr = wrap_addr[`AHB_ADDR_W-1:2];
                            offset_d = offset_inc;
                            count_d = count_q + 2'd1;
                        end
                    end else begin
                        // Bursts other than WRAP4 are served beat by beat like SINGLE.
                        beat_d.valid = 1'b1;
                        beat_d.write = ap.write;
                        beat_d.word_addr = ap.addr[`AHB_ADDR_W-1:2];
                        state_d = SINGLE_ST;
                    end
                end
                default: begin
                    state_d = IDLE_ST;
                end
            endcase
        end
    end

    // ################################################
    // Registers
    // ################################################

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= IDLE_ST;
            base_q <= '0;
            offset_q <= '0;
            count_q <= '0;
            beat <= '0;
        end else begin
            state_q <= state_d;
            base_q <= base_d;
            offset_q <= offset_d;
            count_q <= count_d;
            beat <= beat_d;
        end
    end

endmodule

// File: hw/bank_router.sv
`timescale 1ns/1ps
`include "ahb_settings.svh"

module bank_router
    import mem_pkg::*;
(
    input  mem_beat_t                       beat,
    input  logic                            hready,
    output bank_req_t [`MEM_NUM_BANKS-1:0]  bank_req,
    output logic [BANK_W-1:0]               bank_sel
);

    logic [BANK_W-1:0] bank_idx;
    logic [ROW_W-1:0] row_idx;
    logic [`MEM_NUM_BANKS-1:0] bank_hit;
    logic wr_commit;

    // ################################################
    // Address decode
    // ################################################

    // Word bits 1:0 are byte bits 3:2, the interleave bits.
    // The row comes from the word bits just above them, byte bits 9:4.
    assign bank_idx = beat.word_addr[BANK_W-1:0];
    assign row_idx = beat.word_addr[BANK_W +: ROW_W];

    // A write only lands at the edge that ends the data phase.
    assign wr_commit = beat.valid && beat.write && hready;

    always_comb begin
        for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
            bank_hit[b] = beat.valid && (bank_idx == BANK_W'(b));
        end
    end

    // ################################################
    // Per-bank requests
    // ################################################

    always_comb begin
        for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
            bank_req[b].en = bank_hit[b];
            bank_req[b].write = bank_hit[b] && wr_commit;
            bank_req[b].row = row_idx;
        end
    end

    // The read path needs the bank index of the same beat.
    assign bank_sel = bank_idx;

endmodule

// File: hw/sram_bank.sv
`timescale 1ns/1ps
`include "ahb_settings.svh"

module sram_bank
    import mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  bank_req_t              req,
    input  logic [`AHB_DATA_W-1:0] wdata,
    output logic [`AHB_DATA_W-1:0] rd_data
);

    logic [`AHB_DATA_W-1:0] mem [`MEM_BANK_DEPTH];

    // ################################################
    // Storage
    // ################################################

    // The array starts out zeroed so that reads before any write return 0.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `MEM_BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (req.en && req.write) begin
            mem[req.row] <= wdata;
        end
    end

    // Read is asynchronous, so the word is there within the data phase.
    assign rd_data = mem[req.row];

endmodule

// File: hw/read_return_mux.sv
`timescale 1ns/1ps
`include "ahb_settings.svh"

module read_return_mux
    import mem_pkg::*;
(
    input  logic                                         clk,
    input  logic                                         rstn,
    input  logic [`MEM_NUM_BANKS-1:0][`AHB_DATA_W-1:0]   rd_data,
    input  logic [BANK_W-1:0]                            bank_sel,
    input  mem_beat_t                                    beat,
    input  logic                                         hready,
    output logic [`AHB_DATA_W-1:0]                       hrdata
);

    logic rd_phase;
    logic [`AHB_DATA_W-1:0] sel_word;
    logic [`AHB_DATA_W-1:0] hold_q;

    // A read data phase that completes in this cycle.
    assign rd_phase = beat.valid && !beat.write && hready;

    assign sel_word = rd_data[bank_sel];

    // Live data during a read, last returned word otherwise.
    assign hrdata = rd_phase ? sel_word : hold_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hold_q <= '0;
        end else if (rd_phase) begin
            hold_q <= sel_word;
        end
    end

endmodule

// File: hw/ahb_burst_mem.sv
`timescale 1ns/1ps
`include "ahb_settings.svh"

module ahb_burst_mem
    import ahb_pkg::*;
    import mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`AHB_ADDR_W-1:0] haddr,
    input  logic                   hwrite,
    input  htrans_e                htrans,
    input  hburst_e                hburst,
    input  logic [`AHB_DATA_W-1:0] hwdata,
    input  logic                   hready,
    output logic [`AHB_DATA_W-1:0] hrdata
);

    mem_beat_t beat;
    bank_req_t [`MEM_NUM_BANKS-1:0] bank_req;
    logic [BANK_W-1:0] bank_sel;
    logic [`MEM_NUM_BANKS-1:0][`AHB_DATA_W-1:0] rd_data;

    burst_addr_gen burst_addr_gen_i (
        .clk    (clk),
        .rstn   (rstn),
        .haddr  (haddr),
        .hwrite (hwrite),
        .htrans (htrans),
        .hburst (hburst),
        .hready (hready),
        .beat   (beat)
    );

    bank_router bank_router_i (
        .beat     (beat),
        .hready   (hready),
        .bank_req (bank_req),
        .bank_sel (bank_sel)
    );

    // ################################################
    // Interleaved banks
    // ################################################

    for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
        sram_bank sram_bank_i (
            .clk     (clk),
            .rstn    (rstn),
            .req     (bank_req[b]),
            .wdata   (hwdata),
            .rd_data (rd_data[b])
        );
    end

    read_return_mux read_return_mux_i (
        .clk      (clk),
        .rstn     (rstn),
        .rd_data  (rd_data),
        .bank_sel (bank_sel),
        .beat     (beat),
        .hready   (hready),
        .hrdata   (hrdata)
    );

endmodule

// File: sim/ahb_mem_checker.sv
`timescale 1ns/1ps
`include "ahb_settings.svh"

module ahb_mem_checker
    import ahb_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`AHB_ADDR_W-1:0] haddr,
    input  logic                   hwrite,
    input  htrans_e                htrans,
    input  hburst_e                hburst,
    input  logic [`AHB_DATA_W-1:0] hwdata,
    input  logic                   hready,
    input  logic [`AHB_DATA_W-1:0] hrdata,
    output int                     err_count,
    output int                     check_count
);

    localparam int MODEL_WORDS = `MEM_NUM_BANKS * `MEM_BANK_DEPTH;

    logic [`AHB_DATA_W-1:0] model [MODEL_WORDS];

    // Data phase that follows the last accepted address phase.
    logic                   dp_valid;
    logic                   dp_write;
    logic [`AHB_ADDR_W-1:0] dp_addr;

    logic [`AHB_ADDR_W-1:0] burst_start;
    logic                   wrap_burst;
    int                     beat_k;

    // Word that the bus returned at the last completed read.
    logic [`AHB_DATA_W-1:0] last_rdata;

    // Beat k of a WRAP4 burst stays inside the 16-byte block of its start address.
    function automatic logic [`AHB_ADDR_W-1:0] expected_addr(input logic [`AHB_ADDR_W-1:0] start,
                                                             input int k);
        logic [3:0] offs;
        offs = start[3:0] + 4'(4 * k);
        return (start & `AHB_WRAP4_MASK) | {28'd0, offs[3:2], 2'b00};
    endfunction

    // The memory only decodes enough word bits to cover its size.
    function automatic int model_index(input logic [`AHB_ADDR_W-1:0] addr);
        return int'((addr >> 2) % MODEL_WORDS);
    endfunction

    // ################################################
    // Reference model and compare
    // ################################################

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < MODEL_WORDS; i++) begin
                model[i] = '0;
            end
            dp_valid = 1'b0;
            wrap_burst = 1'b0;
            beat_k = 0;
            last_rdata = '0;
            err_count = 0;
            check_count = 0;
        end else begin
            // Outside a completed read the bus keeps the last returned word.
            if (!(hready && dp_valid && !dp_write) && hrdata !== last_rdata) begin
                err_count++;
                $display("ERROR %s: held hrdata expected 0x%08h actual 0x%08h",
                         tb_ahb_burst_mem.test_name, last_rdata, hrdata);
            end
            if (hready) begin
                if (dp_valid) begin
                    if (dp_write) begin
                        model[model_index(dp_addr)] = hwdata;
                    end else begin
                        check_count++;
                        if (hrdata !== model[model_index(dp_addr)]) begin
                            err_count++;
                            $display("ERROR %s: addr 0x%08h expected 0x%08h actual 0x%08h",
                                     tb_ahb_burst_mem.test_name, dp_addr,
                                     model[model_index(dp_addr)], hrdata);
                        end
                        last_rdata = model[model_index(dp_addr)];
                    end
                end
                dp_valid = 1'b0;
                if (htrans == NONSEQ) begin
                    burst_start = haddr;
                    wrap_burst = (hburst == WRAP4);
                    beat_k = 0;
                    dp_valid = 1'b1;
                    dp_write = hwrite;
                    dp_addr = haddr;
                end else if (htrans == SEQ) begin
                    if (!wrap_burst) begin
                        dp_valid = 1'b1;
                        dp_write = hwrite;
                        dp_addr = haddr;
                    end else if (beat_k < 3) begin
                        beat_k++;
                        dp_valid = 1'b1;
                        dp_write = hwrite;
                        dp_addr = expected_addr(burst_start, beat_k);
                    end
                end
            end
        end
    end

endmodule

// File: sim/tb_ahb_burst_mem.sv
`timescale 1ns/1ps
`include "ahb_settings.svh"

module tb_ahb_burst_mem
    import ahb_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS = 6;
    localparam int MAX_BEATS_PER_TEST = 64;
    // One cycle for the beat plus up to four wait states.
    localparam int WORST_STALL_CYCLES = 5;
    localparam int TIMEOUT_NS = NUM_TESTS * MAX_BEATS_PER_TEST * WORST_STALL_CYCLES * CLK_PERIOD
                                + RESET_CYCLES * CLK_PERIOD + 2000;

    logic                   clk;
    logic                   rstn;
    logic [`AHB_ADDR_W-1:0] haddr;
    logic                   hwrite;
    htrans_e                htrans;
    hburst_e                hburst;
    logic [`AHB_DATA_W-1:0] hwdata;
    logic                   hready;
    logic [`AHB_DATA_W-1:0] hrdata;

    string       test_name;
    logic [31:0] lcg_state = 32'h008f5ff8;
    bit          stalls_on;
    logic        pend_write;
    logic [31:0] pend_wdata;
    int          err_count;
    int          check_count;

    ahb_burst_mem ahb_burst_mem_i (
        .clk    (clk),
        .rstn   (rstn),
        .haddr  (haddr),
        .hwrite (hwrite),
        .htrans (htrans),
        .hburst (hburst),
        .hwdata (hwdata),
        .hready (hready),
        .hrdata (hrdata)
    );

    ahb_mem_checker checker_i (
        .clk         (clk),
        .rstn        (rstn),
        .haddr       (haddr),
        .hwrite      (hwrite),
        .htrans      (htrans),
        .hburst      (hburst),
        .hwdata      (hwdata),
        .hready      (hready),
        .hrdata      (hrdata),
        .err_count   (err_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] word_addr(input logic [31:0] r);
        return {22'd0, r[9:2], 2'b00};
    endfunction

    // ################################################
    // Bus driver
    // ################################################

    // One address phase, carrying the write data of the previous beat.
    task automatic bus_cycle(input htrans_e trans, input hburst_e burst, input logic write,
                             input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] r;
        int stall;
        r = lcg_next();
        stall = (stalls_on && r[7:0] >= 8'd150) ? int'(r[9:8]) + 1 : 0;
        @(negedge clk);
        htrans = trans;
        hburst = burst;
        hwrite = write;
        haddr = addr;
        hwdata = pend_write ? pend_wdata : lcg_next();
        hready = (stall == 0);
        while (stall > 0) begin
            @(negedge clk);
            stall--;
            hready = (stall == 0);
        end
        pend_write = (trans == NONSEQ || trans == SEQ) && write;
        pend_wdata = wdata;
    endtask

    task automatic single_xfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata);
        bus_cycle(NONSEQ, SINGLE, write, addr, wdata);
    endtask

    // SEQ beats either carry the proper wrapped address or junk.
    task automatic wrap4_burst(input logic write, input logic [31:0] start, input bit junk);
        logic [31:0] a;
        for (int k = 0; k < 4; k++) begin
            if (k == 0) begin
                a = start;
            end else if (junk) begin
                a = lcg_next();
            end else begin
                a = {start[31:4], start[3:0] + 4'(4 * k)};
            end
            bus_cycle(k == 0 ? NONSEQ : SEQ, WRAP4, write, a, lcg_next());
        end
    endtask

    task automatic idle_cycle();
        bus_cycle(IDLE, SINGLE, 1'b0, lcg_next(), 32'd0);
    endtask

    // Lets the last data phase finish before the test name changes.
    task automatic end_test();
        idle_cycle();
        @(negedge clk);
    endtask

    // ################################################
    // Tests
    // ################################################

    task automatic reads_after_reset();
        test_name = "reset_reads";
        for (int i = 0; i < 8; i++) begin
            single_xfer(1'b0, word_addr(lcg_next()), 32'd0);
        end
        end_test();
    endtask

    task automatic single_write_read();
        test_name = "single_rw";
        for (int i = 0; i < 16; i++) begin
            single_xfer(1'b1, 32'h100 + 32'(i * 20), lcg_next());
        end
        for (int i = 0; i < 16; i++) begin
            single_xfer(1'b0, 32'h100 + 32'(i * 20), 32'd0);
        end
        end_test();
    endtask

    task automatic wrap_write_then_read();
        test_name = "wrap_write";
        wrap4_burst(1'b1, 32'h38, 1'b0);
        for (int i = 0; i < 4; i++) begin
            single_xfer(1'b0, 32'h30 + 32'(i * 4), 32'd0);
        end
        end_test();
    endtask

    task automatic wrap_read_ignores_haddr();
        logic [31:0] start;
        test_name = "wrap_read_junk";
        wrap4_burst(1'b1, 32'h84, 1'b0);
        wrap4_burst(1'b0, 32'h88, 1'b1);
        start = word_addr(lcg_next());
        wrap4_burst(1'b1, start, 1'b1);
        // The read starts elsewhere in the same 16-byte block.
        wrap4_burst(1'b0, {start[31:4], start[3:0] + 4'd8}, 1'b1);
        end_test();
    endtask

    task automatic stalled_transfers();
        logic [31:0] addrs [8];
        logic [31:0] start;
        test_name = "random_stalls";
        stalls_on = 1'b1;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = word_addr(lcg_next());
            single_xfer(1'b1, addrs[i], lcg_next());
        end
        start = word_addr(lcg_next());
        wrap4_burst(1'b1, start, 1'b0);
        wrap4_burst(1'b0, start, 1'b1);
        for (int i = 0; i < 8; i++) begin
            single_xfer(1'b0, addrs[i], 32'd0);
        end
        end_test();
        stalls_on = 1'b0;
    endtask

    task automatic gaps_and_back_to_back();
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        test_name = "idle_gaps";
        a0 = word_addr(lcg_next());
        a1 = word_addr(lcg_next());
        a2 = word_addr(lcg_next());
        single_xfer(1'b1, a0, lcg_next());
        idle_cycle();
        idle_cycle();
        wrap4_burst(1'b1, a1, 1'b0);
        idle_cycle();
        single_xfer(1'b0, a0, 32'd0);
        idle_cycle();
        wrap4_burst(1'b0, a1, 1'b0);
        end_test();
        test_name = "back_to_back";
        wrap4_burst(1'b1, a1, 1'b0);
        wrap4_burst(1'b1, a2, 1'b0);
        wrap4_burst(1'b0, a1, 1'b0);
        wrap4_burst(1'b0, a2, 1'b1);
        single_xfer(1'b0, a0, 32'd0);
        end_test();
    endtask

    // ################################################
    // Main sequence and watchdog
    // ################################################

    initial begin
        rstn = 1'b0;
        haddr = '0;
        hwrite = 1'b0;
        htrans = IDLE;
        hburst = SINGLE;
        hwdata = '0;
        hready = 1'b1;
        stalls_on = 1'b0;
        pend_write = 1'b0;
        pend_wdata = '0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        reads_after_reset();
        single_write_read();
        wrap_write_then_read();
        wrap_read_ignores_haddr();
        stalled_transfers();
        gaps_and_back_to_back();
        repeat (2) idle_cycle();
        @(posedge clk);

        $display("Read checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0 && check_count > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            if (check_count == 0) begin
                $display("No read data was compared during the run.");
            end
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns.", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+include
hw/ahb_pkg.sv
hw/mem_pkg.sv
hw/burst_addr_gen.sv
hw/bank_router.sv
hw/sram_bank.sv
hw/read_return_mux.sv
hw/ahb_burst_mem.sv
sim/ahb_mem_checker.sv
sim/tb_ahb_burst_mem.sv

// File: Makefile
# Verilator build for the AHB-Lite burst memory.

VERILATOR ?= verilator
TOP       ?= tb_ahb_burst_mem
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?=
PASS_MSG  ?= ALL CHECKS PASSED

COMMON = --timing --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON) $(VFLAGS)

build:
	$(VERILATOR) --binary $(COMMON) $(VFLAGS) --Mdir $(BUILD_DIR) -o V$(TOP)

# The run passes only if the pass message shows up as a line of its own.
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
